/* src/icache_pkg.sv */
package icache_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Address and data widths.
	////////////////////////////////////////////////////////////////////////////

	typedef logic [31:0] addr_t;
	typedef logic [31:0] word_t;

	// Start address after reset.
	localparam addr_t RESET_PC = 32'h0000_0100;

	////////////////////////////////////////////////////////////////////////////
	// Cache geometry and entry layout.
	////////////////////////////////////////////////////////////////////////////

	// The index is taken from address bits 9 down to 2.
	localparam int ICACHE_INDEX_BITS = 8;
	localparam int ICACHE_DEPTH = 1 << ICACHE_INDEX_BITS;

	typedef logic [ICACHE_INDEX_BITS - 1:0] index_t;

	// Stored where the always-zero low address bits would be.
	localparam logic [1:0] VALID_MARK = 2'b01;

	// A cleared entry has a zero mark and therefore never matches.
	typedef struct packed {
		word_t instr;
		word_t tag;
	} cache_entry_t;

endpackage

/* src/cache_ram.sv */
`timescale 1ns/1ps

module cache_ram (
	input  logic                      i_clock,
	input  logic                      i_rst_n,
	input  icache_pkg::index_t        i_index,
	input  logic                      i_write,
	input  icache_pkg::cache_entry_t  i_wdata,
	output icache_pkg::cache_entry_t  o_rdata,
	output logic                      o_initialized
);

	icache_pkg::cache_entry_t mem [icache_pkg::ICACHE_DEPTH];

	icache_pkg::index_t clear_index;
	icache_pkg::index_t address;

	// The clear walk owns the port until every entry holds zeros.
	assign address = o_initialized ? i_index : clear_index;

	////////////////////////////////////////////////////////////////////////////
	// Clear sequencer.
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			clear_index <= '0;
			o_initialized <= 1'b0;
		end
		else if (!o_initialized) begin
			clear_index <= clear_index + 1'b1;
			if (clear_index == icache_pkg::index_t'(icache_pkg::ICACHE_DEPTH - 1)) begin
				o_initialized <= 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Storage.
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clock) begin
		if (!o_initialized) begin
			mem[address] <= '0;
		end
		else if (i_write) begin
			mem[address] <= i_wdata;
		end
	end

	// Registered read, data follows the index by one cycle.
	always_ff @(posedge i_clock) begin
		o_rdata <= mem[address];
	end

	// Once the array is clear it stays usable until the next reset.
	a_init_sticky: assert property (
		@(posedge i_clock) disable iff (!i_rst_n)
		o_initialized |=> o_initialized
	);

endmodule

/* src/icache.sv */
`timescale 1ns/1ps

module icache (
	input  logic                      i_clock,
	input  logic                      i_rst_n,

	input  icache_pkg::addr_t         i_pc,
	input  logic                      i_stall,
	output icache_pkg::word_t         o_instr,
	output logic                      o_ready,
	output logic                      o_busy,

	output logic                      o_bus_request,
	output icache_pkg::addr_t         o_bus_address,
	input  logic                      i_bus_ready,
	input  icache_pkg::word_t         i_bus_rdata,

	output icache_pkg::index_t        o_ram_index,
	output logic                      o_ram_write,
	output icache_pkg::cache_entry_t  o_ram_wdata,
	input  icache_pkg::cache_entry_t  i_ram_rdata,
	input  logic                      i_ram_initialized
);

	typedef enum int {
		S_IDLE   = 0,
		S_LOOKUP = 1,
		S_STREAM = 2,
		S_BUS    = 3
	} state_e;

	logic [3:0] state;
	logic [3:0] next_state;

	icache_pkg::addr_t cache_pc;
	icache_pkg::word_t pc_tag;
	logic hit;

	assign pc_tag = {i_pc[31:2], icache_pkg::VALID_MARK};
	assign hit = (i_ram_rdata.tag == pc_tag);

	assign o_ram_index = cache_pc[icache_pkg::ICACHE_INDEX_BITS + 1:2];
	assign o_bus_address = i_pc;

	// The pc must not move while a request is open on the bus.
	assign o_busy = o_bus_request;

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= 4'b0001 << S_IDLE;
		end
		else begin
			state <= next_state;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Next state and outputs.
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		next_state = '0;
		o_ready = 1'b0;
		o_instr = '0;
		o_bus_request = 1'b0;
		o_ram_write = 1'b0;
		o_ram_wdata = '0;
		cache_pc = i_pc;

		case (1'b1)
			state[S_IDLE]: begin
				if (i_stall) begin
					next_state[S_IDLE] = 1'b1;
				end
				else if (i_ram_initialized) begin
					next_state[S_LOOKUP] = 1'b1;
				end
				else begin
					// Cache not usable yet, go straight to memory.
					o_bus_request = 1'b1;
					next_state[S_BUS] = 1'b1;
				end
			end

			state[S_LOOKUP]: begin
				if (hit) begin
					o_ready = 1'b1;
					o_instr = i_ram_rdata.instr;
					cache_pc = i_pc + 32'd4;
					next_state[S_STREAM] = 1'b1;
				end
				else if (!i_stall) begin
					o_bus_request = 1'b1;
					next_state[S_BUS] = 1'b1;
				end
				else begin
					next_state[S_IDLE] = 1'b1;
				end
			end

			state[S_STREAM]: begin
				if (!i_stall && hit) begin
					o_ready = 1'b1;
					o_instr = i_ram_rdata.instr;
					cache_pc = i_pc + 32'd4;
					next_state[S_STREAM] = 1'b1;
				end
				else if (!i_stall) begin
					o_bus_request = 1'b1;
					next_state[S_BUS] = 1'b1;
				end
				else begin
					next_state[S_IDLE] = 1'b1;
				end
			end

			state[S_BUS]: begin
				o_bus_request = 1'b1;
				if (i_bus_ready) begin
					o_ram_write = 1'b1;
					o_ram_wdata = {i_bus_rdata, pc_tag};
					o_ready = 1'b1;
					o_instr = i_bus_rdata;
					next_state[S_IDLE] = 1'b1;
				end
				else begin
					next_state[S_BUS] = 1'b1;
				end
			end

			default: begin
				next_state[S_IDLE] = 1'b1;
			end
		endcase
	end

	// An open request holds its address, which relies on the fetch unit seeing busy.
	a_request_held: assert property (
		@(posedge i_clock) disable iff (!i_rst_n)
		o_bus_request && !i_bus_ready |=> o_bus_request && $stable(o_bus_address)
	);

	// A bus answer to an open request is delivered in the cycle it arrives.
	a_ready_with_request: assert property (
		@(posedge i_clock) disable iff (!i_rst_n)
		o_bus_request |-> o_ready == i_bus_ready
	);

endmodule

/* src/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit (
	input  logic               i_clock,
	input  logic               i_rst_n,
	input  logic               i_instr_ready,
	input  logic               i_busy,
	input  logic               i_redirect,
	input  icache_pkg::addr_t  i_redirect_pc,
	output icache_pkg::addr_t  o_pc,
	output icache_pkg::addr_t  o_instr_pc
);

	logic redirect_pending;
	icache_pkg::addr_t redirect_target;
	logic apply_redirect;

	// A redirect waits until no bus fill is running.
	assign apply_redirect = redirect_pending && !i_busy;

	// The cache always delivers the word at the current pc.
	assign o_instr_pc = o_pc;

	////////////////////////////////////////////////////////////////////////////
	// Pending redirect.
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			redirect_pending <= 1'b0;
		end
		else if (i_redirect) begin
			redirect_pending <= 1'b1;
		end
		else if (apply_redirect) begin
			redirect_pending <= 1'b0;
		end
	end

	// A newer redirect replaces an older one not yet taken.
	always_ff @(posedge i_clock) begin
		if (i_redirect) begin
			redirect_target <= i_redirect_pc;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Program counter.
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_pc <= icache_pkg::RESET_PC;
		end
		else if (apply_redirect) begin
			o_pc <= redirect_target;
		end
		else if (i_instr_ready) begin
			o_pc <= o_pc + 32'd4;
		end
	end

	a_pc_aligned: assert property (
		@(posedge i_clock) disable iff (!i_rst_n)
		o_pc[1:0] == 2'b00
	);

endmodule

/* src/fetch_top.sv */
`timescale 1ns/1ps

module fetch_top (
	input  logic               i_clock,
	input  logic               i_rst_n,

	input  logic               i_stall,
	input  logic               i_redirect,
	input  icache_pkg::addr_t  i_redirect_pc,
	output logic               o_instr_valid,
	output icache_pkg::word_t  o_instr,
	output icache_pkg::addr_t  o_instr_pc,

	output logic               o_bus_request,
	output icache_pkg::addr_t  o_bus_address,
	input  logic               i_bus_ready,
	input  icache_pkg::word_t  i_bus_rdata
);

	icache_pkg::addr_t pc;
	logic busy;

	icache_pkg::index_t ram_index;
	logic ram_write;
	icache_pkg::cache_entry_t ram_wdata;
	icache_pkg::cache_entry_t ram_rdata;
	logic ram_initialized;

	fetch_unit u_fetch_unit (
		.i_clock        (i_clock),
		.i_rst_n        (i_rst_n),
		.i_instr_ready  (o_instr_valid),
		.i_busy         (busy),
		.i_redirect     (i_redirect),
		.i_redirect_pc  (i_redirect_pc),
		.o_pc           (pc),
		.o_instr_pc     (o_instr_pc)
	);

	icache u_icache (
		.i_clock            (i_clock),
		.i_rst_n            (i_rst_n),
		.i_pc               (pc),
		.i_stall            (i_stall),
		.o_instr            (o_instr),
		.o_ready            (o_instr_valid),
		.o_busy             (busy),
		.o_bus_request      (o_bus_request),
		.o_bus_address      (o_bus_address),
		.i_bus_ready        (i_bus_ready),
		.i_bus_rdata        (i_bus_rdata),
		.o_ram_index        (ram_index),
		.o_ram_write        (ram_write),
		.o_ram_wdata        (ram_wdata),
		.i_ram_rdata        (ram_rdata),
		.i_ram_initialized  (ram_initialized)
	);

	cache_ram u_cache_ram (
		.i_clock        (i_clock),
		.i_rst_n        (i_rst_n),
		.i_index        (ram_index),
		.i_write        (ram_write),
		.i_wdata        (ram_wdata),
		.o_rdata        (ram_rdata),
		.o_initialized  (ram_initialized)
	);

endmodule

/* test/tb_fetch_top.sv */
`timescale 1ns/1ps

module tb_fetch_top;

	localparam logic [31:0] SEED = 32'h6028031b;
	localparam int TIMEOUT = 4000;

	logic i_clock;
	logic i_rst_n;
	logic i_stall;
	logic i_redirect;
	icache_pkg::addr_t i_redirect_pc;
	logic o_instr_valid;
	icache_pkg::word_t o_instr;
	icache_pkg::addr_t o_instr_pc;
	logic o_bus_request;
	icache_pkg::addr_t o_bus_address;
	logic i_bus_ready;
	icache_pkg::word_t i_bus_rdata;

	logic [31:0] stim_seed;
	logic [31:0] bus_seed;
	int bus_wait;
	logic bus_active;
	logic req_seen;

	// Last pc delivered through a bus fill, per cache index.
	icache_pkg::addr_t shadow [icache_pkg::ICACHE_DEPTH];
	icache_pkg::addr_t shadow_pc;
	icache_pkg::addr_t last_pc;
	icache_pkg::addr_t expected_target;
	logic redirect_open;
	logic target_reached;
	int delivery_count;
	int hit_count;

	int data_errors;
	int sequence_errors;
	int redirect_errors;
	int hit_errors;
	int bus_errors;
	int stall_errors;
	int reset_errors;
	int timeouts;

	fetch_top u_dut (
		.i_clock        (i_clock),
		.i_rst_n        (i_rst_n),
		.i_stall        (i_stall),
		.i_redirect     (i_redirect),
		.i_redirect_pc  (i_redirect_pc),
		.o_instr_valid  (o_instr_valid),
		.o_instr        (o_instr),
		.o_instr_pc     (o_instr_pc),
		.o_bus_request  (o_bus_request),
		.o_bus_address  (o_bus_address),
		.i_bus_ready    (i_bus_ready),
		.i_bus_rdata    (i_bus_rdata)
	);

	always #5 i_clock = ~i_clock;

	function automatic logic [31:0] lcg_step(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// Contents of the backing memory at a word address.
	function automatic icache_pkg::word_t memory_word(input icache_pkg::addr_t address);
		return {address[24:0], address[31:25]} ^ 32'hA5A5_1234;
	endfunction

	task automatic draw_stim(input int range, output int value);
		stim_seed = lcg_step(stim_seed);
		value = int'(stim_seed[30:16]) % range;
	endtask

	assign shadow_pc = shadow[o_instr_pc[icache_pkg::ICACHE_INDEX_BITS + 1:2]];

	////////////////////////////////////////////////////////////////////////////
	// Reference state, updated on every clock edge.
	////////////////////////////////////////////////////////////////////////////

	always @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			for (int i = 0; i < icache_pkg::ICACHE_DEPTH; i++) begin
				shadow[i] <= '1;
			end
			last_pc <= icache_pkg::RESET_PC - 32'd4;
			expected_target <= '0;
			redirect_open <= 1'b0;
			target_reached <= 1'b0;
			delivery_count <= 0;
			hit_count <= 0;
			req_seen <= 1'b0;
		end
		else begin
			req_seen <= o_bus_request && !i_bus_ready;
			if (i_redirect) begin
				expected_target <= i_redirect_pc;
				redirect_open <= 1'b1;
				target_reached <= 1'b0;
			end
			else if (o_instr_valid) begin
				// A jump in the stream closes the redirect window.
				if (o_instr_pc != last_pc + 32'd4) begin
					redirect_open <= 1'b0;
				end
				if (o_instr_pc == expected_target) begin
					target_reached <= 1'b1;
				end
			end
			if (o_instr_valid) begin
				last_pc <= o_instr_pc;
				delivery_count <= delivery_count + 1;
				if (o_bus_request) begin
					shadow[o_instr_pc[icache_pkg::ICACHE_INDEX_BITS + 1:2]] <= o_instr_pc;
				end
				else begin
					hit_count <= hit_count + 1;
				end
			end
		end
	end

	// Bus slave. The latency counts from the edge where the request is seen.
	always @(negedge i_clock) begin
		i_bus_ready = 1'b0;
		if (req_seen) begin
			if (!bus_active) begin
				bus_seed = lcg_step(bus_seed);
				bus_wait = int'(bus_seed[17:16]);
				bus_active = 1'b1;
			end
			if (bus_wait == 0) begin
				i_bus_ready = 1'b1;
				i_bus_rdata = memory_word(o_bus_address);
				bus_active = 1'b0;
			end
			else begin
				bus_wait = bus_wait - 1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Checks.
	////////////////////////////////////////////////////////////////////////////

	a_data: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		o_instr_valid |-> o_instr == memory_word(o_instr_pc))
	else begin
		$display("FAIL %0t: word %h at pc %h, expected %h", $time, $sampled(o_instr),
			$sampled(o_instr_pc), memory_word($sampled(o_instr_pc)));
		data_errors++;
	end

	a_sequence: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		o_instr_valid && !redirect_open |-> o_instr_pc == last_pc + 32'd4)
	else begin
		$display("FAIL %0t: pc %h follows %h", $time, $sampled(o_instr_pc), $sampled(last_pc));
		sequence_errors++;
	end

	a_redirect: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		o_instr_valid && redirect_open && o_instr_pc != last_pc + 32'd4
		|-> o_instr_pc == expected_target)
	else begin
		$display("FAIL %0t: pc %h after redirect, expected %h", $time, $sampled(o_instr_pc),
			$sampled(expected_target));
		redirect_errors++;
	end

	a_hit_filled: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		o_instr_valid && !o_bus_request |-> shadow_pc == o_instr_pc)
	else begin
		$display("FAIL %0t: hit at pc %h, index last filled by %h", $time,
			$sampled(o_instr_pc), $sampled(shadow_pc));
		hit_errors++;
	end

	a_bus_stable: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		o_bus_request && !i_bus_ready |=> $stable(o_bus_address))
	else begin
		$display("FAIL %0t: bus address moved to %h during a request", $time,
			$sampled(o_bus_address));
		bus_errors++;
	end

	a_stall_quiet: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		(i_stall && !o_bus_request) ##1 (i_stall && !o_bus_request) |-> !o_instr_valid)
	else begin
		$display("FAIL %0t: delivery of pc %h while stalled", $time, $sampled(o_instr_pc));
		stall_errors++;
	end

	a_reset_quiet: assert property (@(posedge i_clock)
		!i_rst_n |-> !o_instr_valid && !o_bus_request)
	else begin
		$display("FAIL %0t: outputs active during reset", $time);
		reset_errors++;
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus.
	////////////////////////////////////////////////////////////////////////////

	task automatic run_deliveries(input int count, input logic with_stalls);
		int goal;
		int cycles;
		int pick;
		int burst;
		goal = delivery_count + count;
		cycles = 0;
		burst = 0;
		while (delivery_count < goal && cycles < TIMEOUT) begin
			@(negedge i_clock);
			cycles++;
			if (burst > 0) begin
				burst--;
			end
			else if (with_stalls) begin
				draw_stim(8, pick);
				if (pick == 0) begin
					draw_stim(5, burst);
				end
			end
			i_stall = (burst > 0);
		end
		i_stall = 1'b0;
		if (delivery_count < goal) begin
			$display("Timeout: only %0d of %0d instructions were delivered",
				count - (goal - delivery_count), count);
			timeouts++;
		end
	endtask

	// Targets next to the current pc could be reached by the old stream.
	task automatic redirect_to(input icache_pkg::addr_t target);
		int cycles;
		icache_pkg::addr_t aimed;
		@(negedge i_clock);
		aimed = {target[31:2], 2'b00};
		if (aimed == o_instr_pc || aimed == o_instr_pc + 32'd4) begin
			aimed = aimed + 32'd32;
		end
		i_stall = 1'b0;
		i_redirect = 1'b1;
		i_redirect_pc = aimed;
		@(negedge i_clock);
		i_redirect = 1'b0;
		cycles = 0;
		while (!target_reached && cycles < TIMEOUT) begin
			@(negedge i_clock);
			cycles++;
		end
		if (!target_reached) begin
			$display("Timeout: redirect target %h was never delivered", aimed);
			timeouts++;
		end
	endtask

	initial begin
		icache_pkg::addr_t target;
		int pick;
		int offset;
		int total;
		i_clock = 1'b0;
		i_rst_n = 1'b0;
		i_stall = 1'b1;
		i_redirect = 1'b0;
		i_redirect_pc = '0;
		i_bus_ready = 1'b0;
		i_bus_rdata = '0;
		stim_seed = SEED;
		bus_seed = SEED;
		bus_wait = 0;
		bus_active = 1'b0;
		data_errors = 0;
		sequence_errors = 0;
		redirect_errors = 0;
		hit_errors = 0;
		bus_errors = 0;
		stall_errors = 0;
		reset_errors = 0;
		timeouts = 0;

		repeat (16) @(negedge i_clock);
		i_rst_n = 1'b1;
		@(negedge i_clock);
		i_stall = 1'b0;

		// A long straight run outlasts the RAM clear and fills the cache.
		run_deliveries(150, 1'b0);

		for (int i = 0; i < 40; i++) begin
			draw_stim(2, pick);
			if (pick == 0) begin
				draw_stim(256, offset);
				target = 32'h0000_2000 + 32'(offset * 4);
			end
			else begin
				draw_stim(150, offset);
				target = icache_pkg::RESET_PC + 32'(offset * 4);
			end
			redirect_to(target);
			draw_stim(16, offset);
			run_deliveries(8 + offset, 1'b1);
		end

		// The second pass over the start region comes from the cache.
		repeat (2) begin
			redirect_to(icache_pkg::RESET_PC);
			run_deliveries(160, 1'b0);
		end

		a_enough_hits: assert (hit_count >= 100) else begin
			$display("Too few instructions came from the cache: %0d", hit_count);
			hit_errors++;
		end

		total = data_errors + sequence_errors + redirect_errors + hit_errors + bus_errors
			+ stall_errors + reset_errors + timeouts;
		$display("Errors: data %0d, sequence %0d, redirect %0d, hit %0d, ",
			data_errors, sequence_errors, redirect_errors, hit_errors,
			"bus %0d, stall %0d, reset %0d, timeouts %0d; cache hits %0d",
			bus_errors, stall_errors, reset_errors, timeouts, hit_count);
		if (total == 0) begin
			$display("ALL TESTS PASSED");
		end
		else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

/* verilog.f */
src/icache_pkg.sv
src/cache_ram.sv
src/icache.sv
src/fetch_unit.sv
src/fetch_top.sv
test/tb_fetch_top.sv

/* Bender.yml */
package:
  name: fetch_top

sources:
  - src/icache_pkg.sv
  - src/cache_ram.sv
  - src/icache.sv
  - src/fetch_unit.sv
  - src/fetch_top.sv
  - target: test
    files:
      - test/tb_fetch_top.sv
